/* bench/divVectors.txt */
// Columns: a, b, expected q, expected r, expected busy cycles (prep plus loop).
// All hex; busy cycles are zero when a is below b.
FFFFFFFF 00000001 FFFFFFFF 00000000 21
FFFFFFFF FFFFFFFF 00000001 00000000 21
80000000 00000002 40000000 00000000 21
80000001 00000002 40000000 00000001 21
FFFFFFFF 00010000 0000FFFF 0000FFFF 21
DEADBEEF 00000010 0DEADBEE 0000000F 21
87654321 00000100 00876543 00000021 21
FFFFFFFF 80000000 00000001 7FFFFFFF 21
C0000000 40000000 00000003 00000000 21
F0000000 0000000F 10000000 00000000 21
// Divisor above the dividend.
00000000 00000001 00000000 00000000 00
00000005 00000006 00000000 00000005 00
9ABCDEF0 00001000 0009ABCD 00000EF0 21
FFFFFFFE 00000003 55555554 00000002 21
7FFFFFFF 00000001 7FFFFFFF 00000000 20
40000000 00000003 15555555 00000001 20
00FFFFFF 00000100 0000FFFF 000000FF 19
00010000 00000010 00001000 00000000 12
7FFFFFFF 80000000 00000000 7FFFFFFF 00
0000FFFF 000000FF 00000101 00000000 11
00001234 00000010 00000123 00000004 0E
00000100 00000007 00000024 00000004 0A
00000001 00000001 00000001 00000000 02
00000002 00000002 00000001 00000000 03
00000003 00000002 00000001 00000001 03
00001234 00001235 00000000 00001234 00
0000000F 00000004 00000003 00000003 05
000000FF 00000010 0000000F 0000000F 09
12345678 00010000 00001234 00005678 1E
3FFFFFFF 00000002 1FFFFFFF 00000001 1F
0ABCDEF0 00000100 000ABCDE 000000F0 1D
00ABCDEF 00ABCDEF 00000001 00000000 19
FFFFFFFE FFFFFFFF 00000000 FFFFFFFE 00
000003E8 00000007 0000008E 00000006 0B
0001E240 000003E8 0000007B 000001C8 12
05F5E100 00002710 00002710 00000000 1C
00000064 00000064 00000001 00000000 08
00000065 00000032 00000002 00000001 08
00000007 00000007 00000001 00000000 04
FFFF0000 0000FFFF 00010000 00000000 21

/* quickDivider.f */
verilog/divWidthPkg.sv
verilog/divCtrlPkg.sv
verilog/leadNormalizer.sv
verilog/divSequencer.sv
verilog/iterCounter.sv
verilog/restoreDatapath.sv
verilog/quickDivider.sv
bench/divClockGen.sv
bench/quickDivider_assert.sv
bench/quickDividerTb.sv

/* Makefile */
# Verilator build and run for the quick start divider.

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= quickDividerTb
FILELIST  ?= quickDivider.f
OBJDIR    ?= obj_dir
SIMARGS   ?= +verilator+error+limit+100
PASSMSG   := Test OK

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check for the pass message"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	@out="$$(./$(OBJDIR)/V$(TOP) $(SIMARGS) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASSMSG)"

clean:
	rm -rf $(OBJDIR)

/* bench/quickDividerTb.sv */
/*
 * Testbench for the quick start divider.
 * Runs every line of divVectors.txt and checks q, r and the busy length.
 */

`timescale 1ns/1ns

module quickDividerTb;

  import divWidthPkg::*;

  localparam int dataWidth   = widthDefault;
  localparam int resetCycles = 3;
  localparam int vecCount    = 40; // Divisions in the vector file.
  localparam int vecFields   = 5;  // a, b, q, r, busy cycles.

  logic                 clk;
  logic                 rstLow;
  logic [dataWidth-1:0] a;
  logic [dataWidth-1:0] b;
  logic                 start;
  logic [dataWidth-1:0] q;
  logic [dataWidth-1:0] r;
  logic                 busy;

  logic [dataWidth-1:0] vecMem [0:vecCount*vecFields-1]; // Flat vector words.
  int                   errorCount = 0;
  int                   cycleCount = 0;
  int                   cycleLimit = 0; // Zero until vectors are loaded.

  divClockGen #(
    .halfPeriod (4),
    .resetCycles(resetCycles)
  ) clockGen (
    .clk   (clk),
    .rstLow(rstLow)
  );

  quickDivider #(
    .dataWidth(dataWidth)
  ) quickDivider_inst (
    .clk   (clk),
    .rstLow(rstLow),
    .a     (a),
    .b     (b),
    .start (start),
    .q     (q),
    .r     (r),
    .busy  (busy)
  );

  // ****************************************
  // Bound control checks.
  // ****************************************
  bind divSequencer quickDivider_assert #(
    .dataWidth(divWidthPkg::widthDefault)
  ) seqChecks (
    .clk     (clk),
    .rstLow  (rstLow),
    .init    (init),
    .busy    (busy),
    .startOk (startOk),
    .iterDone(iterDone)
  );

  bind iterCounter quickDivider_assert #(
    .dataWidth(dataWidth)
  ) cntChecks (
    .clk     (clk),
    .rstLow  (rstLow),
    .init    (init),
    .busy    (busy),
    .startOk (1'b0), // No start strobe at the counter.
    .iterDone(iterDone)
  );

  // Common end of every failed check.
  task automatic abortRun(input string why);
    errorCount++;
    $display("%s", why);
    $display("Test FAILED");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic checkData(input string name, input logic [dataWidth-1:0] got,
                           input logic [dataWidth-1:0] exp);
    if (got !== exp) begin
      abortRun($sformatf("error %s: got 0x%h, expected 0x%h", name, got, exp));
    end
  endtask

  task automatic checkCycles(input string name, input int got, input int exp);
    if (got != exp) begin
      abortRun($sformatf("error %s: got 0x%0h, expected 0x%0h", name, got, exp));
    end
  endtask

  task automatic checkLevel(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      abortRun($sformatf("error %s: got 0x%h, expected 0x%h", name, got, exp));
    end
  endtask

  // Count of zeros above the top set bit.
  function automatic int leadingZeros(input logic [dataWidth-1:0] v);
    int n;
    n = 0;
    while (n < dataWidth && !v[dataWidth-1-n]) begin
      n++;
    end
    return n;
  endfunction

  // Prep plus one loop cycle per significant dividend bit.
  function automatic int expectedBusy(input logic [dataWidth-1:0] va,
                                      input logic [dataWidth-1:0] vb);
    if (va < vb) begin
      return 0; // Bypass never raises busy.
    end
    return 1 + dataWidth - leadingZeros(va);
  endfunction

  // ****************************************
  // One division from the vector file.
  // ****************************************
  task automatic runVector(input int idx);
    logic [dataWidth-1:0] va;
    logic [dataWidth-1:0] vb;
    logic [dataWidth-1:0] vq;
    logic [dataWidth-1:0] vr;
    int                   vCycles;
    int                   expCycles;
    int                   busyLen;
    int                   gap;
    va        = vecMem[idx*vecFields];
    vb        = vecMem[idx*vecFields+1];
    vq        = vecMem[idx*vecFields+2];
    vr        = vecMem[idx*vecFields+3];
    vCycles   = int'(vecMem[idx*vecFields+4]);
    expCycles = expectedBusy(va, vb);
    if (vb == '0) begin
      abortRun($sformatf("vector %0d has a zero divisor or is missing", idx));
    end
    if (vCycles != expCycles || vq != va / vb || vr != va % vb) begin
      abortRun($sformatf("vector %0d does not agree with its own a and b", idx));
    end
    @(posedge clk);
    #1;
    a     = va;
    b     = vb;
    start = 1'b1;
    @(negedge clk);
    checkLevel("busy", busy, 1'b0); // Start not sampled yet.
    if (expCycles == 0) begin
      checkData("q", q, '0); // Bypass shows up at once.
      checkData("r", r, va);
    end
    @(posedge clk);
    #1;
    start   = 1'b0;
    busyLen = 0;
    @(negedge clk);
    while (busy) begin
      busyLen++;
      @(posedge clk);
      #1;
      start = (expCycles >= 8) && (busyLen == 4); // Stray start mid-loop.
      @(negedge clk);
    end
    start = 1'b0;
    checkCycles("busy cycles", busyLen, expCycles);
    checkData("q", q, vq);
    checkData("r", r, vr);
    // Results held while idle.
    gap = int'($urandom % 4);
    repeat (gap) begin
      @(negedge clk);
      checkData("q", q, vq);
      checkData("r", r, vr);
      checkLevel("busy", busy, 1'b0);
    end
  endtask

  // Cycle limit.
  always @(posedge clk) begin
    cycleCount = cycleCount + 1;
    if (cycleLimit > 0 && cycleCount > cycleLimit) begin
      $display("timeout: divisions still running after %0d cycles", cycleCount);
      $display("Test FAILED");
      $fatal(1, "simulation ran past its cycle limit");
    end
  end

  // Bound assertion results.
  always @(negedge clk) begin
    if (quickDivider_inst.sequencer.seqChecks.failCount != 0 ||
        quickDivider_inst.counter.cntChecks.failCount != 0) begin
      $display("a bound assertion on the sequencer or counter failed");
      $display("Test FAILED");
      $fatal(1, "assertion failure");
    end
  end

  // ****************************************
  // Main sequence.
  // ****************************************
  initial begin
    a     = '0; // a equal to b for the reset check.
    b     = '0;
    start = 1'b0;
    void'($urandom(19237));
    $readmemh("bench/divVectors.txt", vecMem);
    cycleLimit = vecCount * (dataWidth + 6) + resetCycles;
    @(posedge rstLow);
    @(negedge clk);
    checkLevel("busy", busy, 1'b0);
    checkData("q", q, '0);
    checkData("r", r, '0);
    for (int i = 0; i < vecCount; i++) begin
      runVector(i);
    end
    // Last cycle's assertion results count too.
    if (errorCount == 0 &&
        quickDivider_inst.sequencer.seqChecks.failCount == 0 &&
        quickDivider_inst.counter.cntChecks.failCount == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

/* bench/quickDivider_assert.sv */
/*
 * Concurrent checks on the divider control.
 * Bound into divSequencer and iterCounter by the testbench.
 */

`timescale 1ns/1ns

module quickDivider_assert #(
  parameter int dataWidth = divWidthPkg::widthDefault
) (
  input logic clk,
  input logic rstLow,
  input logic init,     // Prep strobe.
  input logic busy,     // Division in flight.
  input logic startOk,  // Start not bypassed.
  input logic iterDone  // Counter at all ones.
);

  import divCtrlPkg::*;

  divStateT phase;         // Phase rebuilt from init and busy.
  int       busyRun;       // Busy cycles so far.
  int       failCount = 0; // Watched by the testbench.

  assign phase = init ? prep : (busy ? loop : finish);

  // Length of the current busy stretch.
  always_ff @(posedge clk or negedge rstLow) begin
    if (!rstLow) begin
      busyRun <= 0;
    end else if (busy) begin
      busyRun <= busyRun + 1;
    end else begin
      busyRun <= 0;
    end
  end

  // ****************************************
  // Control properties.
  // ****************************************
  idleAfterReset: assert property (@(posedge clk) $rose(rstLow) |-> !busy)
    else begin
      failCount++;
      $error("busy high right after reset");
    end

  initOneCycle: assert property (@(posedge clk) disable iff (!rstLow) init |=> !init)
    else begin
      failCount++;
      $error("init held for more than one cycle");
    end

  busyBounded: assert property (@(posedge clk) disable iff (!rstLow)
      busyRun <= dataWidth + 1)
    else begin
      failCount++;
      $error("busy longer than dataWidth + 1 cycles");
    end

  // Idle plus a real start means prep next.
  startTakesEffect: assert property (@(posedge clk) disable iff (!rstLow)
      startOk && !busy |=> busy)
    else begin
      failCount++;
      $error("accepted start not followed by busy");
    end

  loopExits: assert property (@(posedge clk) disable iff (!rstLow)
      (phase == loop) && iterDone |=> !busy)
    else begin
      failCount++;
      $error("loop kept running past the last iteration");
    end

endmodule

/* bench/divClockGen.sv */
/*
 * Testbench clock and reset source for the divider.
 * 8 ns clock; active-low reset held for a set number of cycles.
 */

`timescale 1ns/1ns

module divClockGen #(
  parameter int halfPeriod  = 4, // Half of the 8 ns period.
  parameter int resetCycles = 3  // Rising edges under reset.
) (
  output logic clk,
  output logic rstLow
);

  // Free-running clock.
  initial begin
    clk = 1'b0;
    forever #halfPeriod clk = ~clk;
  end

  initial begin
    rstLow = 1'b0; // Asserted from time zero.
    repeat (resetCycles) @(posedge clk);
    #1;
    rstLow = 1'b1; // Released just after an edge.
  end

endmodule

/* verilog/quickDivider.sv */
/*
 * Unsigned restoring divider with quick start, top level.
 * Pulse start with a and b held; q and r are valid when busy falls.
 */

`timescale 1ns/1ns

module quickDivider #(
  parameter int dataWidth = divWidthPkg::widthDefault
) (
  input  logic                 clk,
  input  logic                 rstLow,
  input  logic [dataWidth-1:0] a,     // Dividend.
  input  logic [dataWidth-1:0] b,     // Divisor, never zero.
  input  logic                 start, // Start strobe.
  output logic [dataWidth-1:0] q,     // Quotient.
  output logic [dataWidth-1:0] r,     // Remainder.
  output logic                 busy   // Division in flight.
);

  import divWidthPkg::*;

  localparam int cntWidth = cntWidthOf(dataWidth);

  // ****************************************
  // Internal wires.
  // ****************************************
  logic [dataWidth-1:0] aNorm;       // Normalized dividend.
  logic [cntWidth-1:0]  normShift;   // Leading zeros of a.
  logic                 dividendLow; // a below b.
  logic                 init;        // Prep cycle.
  logic                 iterDone;    // Last loop cycle.

  // Quick start normalization.
  leadNormalizer #(
    .dataWidth(dataWidth)
  ) normalizer (
    .a        (a),
    .aNorm    (aNorm),
    .normShift(normShift)
  );

  // Control FSM.
  divSequencer sequencer (
    .clk        (clk),
    .rstLow     (rstLow),
    .start      (start),
    .dividendLow(dividendLow),
    .iterDone   (iterDone),
    .init       (init),
    .busy       (busy)
  );

  // Loop length.
  iterCounter #(
    .dataWidth(dataWidth)
  ) counter (
    .clk      (clk),
    .rstLow   (rstLow),
    .init     (init),
    .busy     (busy),
    .normShift(normShift),
    .iterDone (iterDone)
  );

  // Quotient and remainder.
  restoreDatapath #(
    .dataWidth(dataWidth)
  ) datapath (
    .clk        (clk),
    .rstLow     (rstLow),
    .init       (init),
    .busy       (busy),
    .a          (a),
    .b          (b),
    .aNorm      (aNorm),
    .q          (q),
    .r          (r),
    .dividendLow(dividendLow)
  );

endmodule

/* verilog/restoreDatapath.sv */
/*
 * Restoring division datapath: quotient and remainder registers.
 * One trial subtraction per loop cycle; a below b bypasses the registers.
 */

`timescale 1ns/1ns

module restoreDatapath #(
  parameter int dataWidth = divWidthPkg::widthDefault
) (
  input  logic                 clk,
  input  logic                 rstLow,
  input  logic                 init,       // Load operands.
  input  logic                 busy,       // Step enable.
  input  logic [dataWidth-1:0] a,          // Raw dividend, for the bypass.
  input  logic [dataWidth-1:0] b,          // Divisor, held by the caller.
  input  logic [dataWidth-1:0] aNorm,      // Normalized dividend.
  output logic [dataWidth-1:0] q,          // Quotient.
  output logic [dataWidth-1:0] r,          // Remainder.
  output logic                 dividendLow // a below b.
);

  logic [dataWidth-1:0] qReg;  // Dividend, shifts into the quotient.
  logic [dataWidth-1:0] rReg;  // Partial remainder.
  logic [dataWidth:0]   trial; // One bit wider, MSB is the borrow.

  // ****************************************
  // Trial subtraction.
  // ****************************************
  // Next dividend bit joins the partial remainder.
  assign trial = {rReg, qReg[dataWidth-1]} - {1'b0, b};

  // Quotient register.
  always_ff @(posedge clk or negedge rstLow) begin
    if (!rstLow) begin
      qReg <= '0;
    end else if (init) begin
      qReg <= aNorm; // Leading zeros already removed.
    end else if (busy) begin
      qReg <= {qReg[dataWidth-2:0], ~trial[dataWidth]}; // No borrow sets a 1.
    end
  end

  // Remainder register.
  always_ff @(posedge clk or negedge rstLow) begin
    if (!rstLow) begin
      rReg <= '0;
    end else if (init) begin
      rReg <= '0;
    end else if (busy) begin
      if (trial[dataWidth]) begin
        rReg <= {rReg[dataWidth-2:0], qReg[dataWidth-1]}; // Restore, shift only.
      end else begin
        rReg <= trial[dataWidth-1:0]; // Keep the difference.
      end
    end
  end

  // ****************************************
  // Bypass for a below b.
  // ****************************************
  // Zero latency; registers keep their old contents meanwhile.
  assign dividendLow = (a < b);
  assign q = dividendLow ? '0 : qReg;
  assign r = dividendLow ? a : rReg;

endmodule

/* verilog/iterCounter.sv */
/*
 * Iteration counter for the restoring loop.
 * Preset with the normalization shift, so short dividends finish early.
 */

`timescale 1ns/1ns

module iterCounter #(
  parameter int dataWidth = divWidthPkg::widthDefault
) (
  input  logic                                          clk,
  input  logic                                          rstLow,
  input  logic                                          init,      // Preset strobe.
  input  logic                                          busy,      // Count enable.
  input  logic [divWidthPkg::cntWidthOf(dataWidth)-1:0] normShift, // Skipped steps.
  output logic                                          iterDone   // Last iteration.
);

  import divWidthPkg::*;

  localparam int cntWidth = cntWidthOf(dataWidth);

  logic [cntWidth-1:0] count; // Steps done, offset by the shift.

  // Runs from normShift up to all ones.
  always_ff @(posedge clk or negedge rstLow) begin
    if (!rstLow) begin
      count <= '0;
    end else if (init) begin
      count <= normShift; // Saved iterations skipped here.
    end else if (busy) begin
      count <= count + 1'b1;
    end
  end

  assign iterDone = &count; // Only sampled by the FSM in loop.

endmodule

/* verilog/divSequencer.sv */
/*
 * Divider FSM: prep for one cycle, then loop until the last iteration.
 * Produces the init strobe and the busy level for the datapath and counter.
 */

`timescale 1ns/1ns

module divSequencer (
  input  logic clk,
  input  logic rstLow,
  input  logic start,       // Start strobe from the caller.
  input  logic dividendLow, // a below b, result is bypassed.
  input  logic iterDone,    // Counter at all ones.
  output logic init,        // High in prep only.
  output logic busy         // High in prep and loop.
);

  import divCtrlPkg::*;

  divStateT state;     // Current state.
  divStateT stateNext; // Next state.
  logic     startOk;   // Start that is not bypassed.

  // Bypassed divisions never enter the loop.
  assign startOk = start & ~dividendLow;

  // ****************************************
  // Next state.
  // ****************************************
  always_comb begin
    stateNext = state;
    case (state)
      prep: begin
        stateNext = loop; // Operands loaded in one cycle.
      end
      loop: begin
        if (iterDone) begin
          stateNext = finish; // Last restoring step done.
        end
      end
      finish, free: begin
        if (startOk) begin
          stateNext = prep; // Starts while busy never get here.
        end
      end
      default: stateNext = free;
    endcase
  end

  // State register.
  always_ff @(posedge clk or negedge rstLow) begin
    if (!rstLow) begin
      state <= free;
    end else begin
      state <= stateNext;
    end
  end

  // ****************************************
  // Output decode.
  // ****************************************
  assign init = (state == prep);
  assign busy = (state == prep) || (state == loop); // Falls when q and r are valid.

endmodule

/* verilog/leadNormalizer.sv */
/*
 * Leading-zero count of the dividend and the left-normalized dividend.
 * Purely combinational; the count presets the iteration counter.
 */

`timescale 1ns/1ns

module leadNormalizer #(
  parameter int dataWidth = divWidthPkg::widthDefault
) (
  input  logic [dataWidth-1:0]                          a,        // Raw dividend.
  output logic [dataWidth-1:0]                          aNorm,    // Leading zeros removed.
  output logic [divWidthPkg::cntWidthOf(dataWidth)-1:0] normShift // Leading-zero count.
);

  import divWidthPkg::*;

  localparam int cntWidth = cntWidthOf(dataWidth);

  logic [cntWidth-1:0] zeroCount; // Result of the priority search.

  // ****************************************
  // Priority search for the top set bit.
  // ****************************************
  // Scan from LSB up, so the highest set bit writes last and wins.
  always_comb begin
    zeroCount = {cntWidth{1'b1}}; // Zero dividend gives max shift.
    for (int i = 0; i < dataWidth; i++) begin
      if (a[i]) begin
        zeroCount = cntWidth'(dataWidth - 1 - i); // Zeros above bit i.
      end
    end
  end

  assign normShift = zeroCount;

  // ****************************************
  // Normalization shift.
  // ****************************************
  // Top set bit lands in the MSB.
  // Shifted-in zeros end up above the quotient bits.
  assign aNorm = a << zeroCount;

endmodule

/* verilog/divCtrlPkg.sv */
/*
 * Control encodings for the divider FSM.
 * Used by the sequencer and by the bound assertions.
 */

package divCtrlPkg;

  // ****************************************
  // Sequencer states.
  // ****************************************
  typedef enum logic [1:0] {
    prep   = 2'd0, // Load operands, preset counter.
    loop   = 2'd1, // One restoring step per cycle.
    finish = 2'd2, // Idle, results held.
    free   = 2'd3  // Reset state, same as finish.
  } divStateT;

endpackage

/* verilog/divWidthPkg.sv */
/*
 * Operand width defaults for the quick start divider.
 * Shared by the RTL and the bench to size data and counter ports.
 */

package divWidthPkg;

  // ****************************************
  // Width defaults.
  // ****************************************
  parameter int widthDefault = 32; // Default dividend and divisor width.

  // Counter bits needed to index every quotient bit.
  // For 32 this gives 5 bits.
  function automatic int cntWidthOf(input int width);
    return $clog2(width); // Base-2 log of the width.
  endfunction

endpackage
